/* intu_pkg.sv */
////////////////////////////////////////
// Execute stage shared definitions
// Opcode codes, MSR bit positions and the
// two views of the 16-bit immediate
////////////////////////////////////////
`default_nettype none

package intu_pkg;

   // Major opcode field of the instruction word
   typedef logic [5:0] opc_t;

   // Opcodes the status unit decodes in full
   localparam opc_t opc_shift = 6'o44;  // SRA/SRC/SRL/SEXT8/SEXT16
   localparam opc_t opc_mov   = 6'o45;  // MTS, MSRSET, MSRCLR
   localparam opc_t opc_rtd   = 6'o55;  // Return group, rd picks the kind
   localparam opc_t opc_brk   = 6'o56;  // Break
   localparam opc_t opc_brki  = 6'o46;  // Break, second encoding

   // Shift and compare view of the immediate
   typedef struct packed {
      logic [8:0] pad_hi;    // Unused here
      logic [1:0] kind;      // 00 SRA, 01 SRC, 10 SRL, 11 SEXT
      logic [2:0] pad_lo;
      logic       cmpu;      // Compare treats operands as unsigned
      logic       mode;      // Shift, or SEXT16 when kind is 11
   } imm_shift_t;

   // Special register view of the immediate
   typedef struct packed {
      logic [1:0] mcls;      // 11 move-to-special, 00 MSR set/clear
      logic [5:0] pad;
      logic [7:0] mask;      // MSR bits touched by set/clear
   } imm_spr_t;

   // One immediate word, decoded by opcode
   typedef union packed {
      imm_shift_t shf;
      imm_spr_t   spr;
   } imm_u;

   // MSR bit positions
   // Bit 6 is not implemented and reads zero
   localparam int unsigned msr_be  = 0;  // Bus lock enable
   localparam int unsigned msr_ie  = 1;  // Interrupt enable
   localparam int unsigned msr_c   = 2;  // Carry
   localparam int unsigned msr_bip = 3;  // Break in progress
   localparam int unsigned msr_mtx = 4;  // Hardware mutex
   localparam int unsigned msr_ite = 5;  // Instruction cache enable
   localparam int unsigned msr_dte = 7;  // Data cache enable

   // ra codes that qualify a break
   localparam logic [4:0] ra_brk_imm = 5'd13;  // Break clears IE
   localparam logic [4:0] ra_brk_bip = 5'd12;  // Break sets BIP

endpackage

`default_nettype wire

/* intu_alu.sv */
////////////////////////////////////////
// Arithmetic and logic unit
// Adder with carry, compare adjust, logic ops,
// one-bit shifts and sign extension
////////////////////////////////////////
`default_nettype none

module intu_alu (
   input  wire intu_pkg::opc_t opc_of,     // Major opcode
   input  wire [31:0]          opa_of,     // Operand A
   input  wire [31:0]          opb_of,     // Operand B
   input  wire intu_pkg::imm_u imm_of,     // Immediate, shift view used here
   input  wire                 carry_cc,   // Carry copy from status unit
   output logic [31:0]         add_res,    // Sum with compare adjust
   output logic [31:0]         add_sum,    // Raw sum for addresses
   output logic [31:0]         slm_res,    // Shift/logic result
   output logic                add_carry,  // Adder carry out
   output logic                shift_out   // Bit shifted out on the right
);

   logic        fsub;      // Reverse subtract group
   logic        fccc;      // Carry variants take CC as carry-in
   logic        fcmp;      // Unsigned compare
   logic [31:0] opa_sel;   // A, inverted for subtract
   logic        cin;       // Adder carry-in
   logic        cmp_msb;   // Replacement for sum bit 31

   // ADD/RSUB/ADDC/RSUBC/CMP decode
   // Opcode bit 0 selects subtract, bit 1 selects carry-in from CC
   assign fsub = ~opc_of[5] & opc_of[0];
   assign fccc = ~opc_of[5] & opc_of[1];
   assign fcmp = ~opc_of[3] & imm_of.shf.cmpu;

   // b - a computed as b + ~a + 1
   assign opa_sel = fsub ? ~opa_of : opa_of;
   assign cin     = fccc ? carry_cc : fsub;  // Plain add has no carry-in

   // One adder for every arithmetic op
   assign {add_carry, add_sum} = {1'b0, opb_of} + {1'b0, opa_sel} + {32'd0, cin};

   // Compare puts the ordering into the sign bit
   // Unsigned: borrow is the inverted carry
   // Signed: the sum sign is used as is
   assign cmp_msb = fcmp ? ~add_carry : add_sum[31];
   assign add_res = {cmp_msb, add_sum[30:0]};

   // LSB of A always falls out of a right shift
   assign shift_out = opa_of[0];

   // Shift, logic and sign extension
   always_comb begin
      case (opc_of[2:0])
         // Logic group
         3'o0: slm_res = opa_of | opb_of;       // OR
         3'o1: slm_res = opa_of & opb_of;       // AND
         3'o2: slm_res = opa_of ^ opb_of;       // XOR
         3'o3: slm_res = opa_of & ~opb_of;      // ANDN
         // Shift group, selected by kind and mode
         3'o4: begin
            case ({imm_of.shf.kind, imm_of.shf.mode})
               3'b001:  slm_res = {opa_of[31], opa_of[31:1]};       // SRA
               3'b011:  slm_res = {carry_cc, opa_of[31:1]};         // SRC through carry
               3'b101:  slm_res = {1'b0, opa_of[31:1]};             // SRL
               3'b110:  slm_res = {{24{opa_of[7]}}, opa_of[7:0]};   // SEXT8
               3'b111:  slm_res = {{16{opa_of[15]}}, opa_of[15:0]}; // SEXT16
               default: slm_res = 32'd0;        // Reserved encodings
            endcase
         end
         // Other codes carry no result from this unit
         default: slm_res = 32'd0;
      endcase
   end

endmodule

`default_nettype wire

/* intu_msr.sv */
////////////////////////////////////////
// Machine status register
// Flag registers, set/clear/move logic,
// carry flag and its one-cycle copy
////////////////////////////////////////
`default_nettype none

module intu_msr (
   input  wire                 gclk,
   input  wire                 grst,
   input  wire                 dena,       // Stage advance
   input  wire intu_pkg::opc_t opc_of,     // Major opcode
   input  wire [31:0]          opa_of,     // Source for move-to-special
   input  wire intu_pkg::imm_u imm_of,     // Special register view used here
   input  wire [4:0]           ra_of,
   input  wire [4:0]           rd_of,
   input  wire                 add_carry,  // From ALU adder
   input  wire                 shift_out,  // From ALU shifter
   output logic [7:0]          msr_bits,   // Live MSR flags
   output logic                carry_cc    // Carry copy back to ALU
);

   logic       msr_dte_q;
   logic       msr_ite_q;
   logic       msr_mtx_q;
   logic       msr_bip_q;
   logic       msr_ie_q;
   logic       msr_be_q;
   logic       msr_c_q;
   logic       msr_cc_q;   // C delayed by one enabled cycle

   logic [7:0] set_clr;    // MSRSET/MSRCLR result
   logic       frtid;      // Return from interrupt
   logic       frtbd;      // Return from break
   logic       fbrki;      // Break that masks interrupts
   logic       fbrkb;      // Break that marks BIP
   logic       fmov;
   logic       fmts;       // Move to special
   logic       fmop;       // MSR set/clear
   logic       fshift;     // True shift, not sign extension
   logic       faddsub;    // Add/sub group writes C

   // Flag layout on the MSR bits
   always_comb begin
      msr_bits = 8'd0;
      msr_bits[intu_pkg::msr_dte] = msr_dte_q;
      msr_bits[intu_pkg::msr_ite] = msr_ite_q;
      msr_bits[intu_pkg::msr_mtx] = msr_mtx_q;
      msr_bits[intu_pkg::msr_bip] = msr_bip_q;
      msr_bits[intu_pkg::msr_c]   = msr_c_q;
      msr_bits[intu_pkg::msr_ie]  = msr_ie_q;
      msr_bits[intu_pkg::msr_be]  = msr_be_q;
   end

   assign carry_cc = msr_cc_q;

   // ra bit 0 picks clear over set
   assign set_clr = ra_of[0] ? (msr_bits & ~imm_of.spr.mask)
                             : (msr_bits | imm_of.spr.mask);

   // Return kinds sit in rd
   assign frtid = (opc_of == intu_pkg::opc_rtd) & rd_of[0];
   assign frtbd = (opc_of == intu_pkg::opc_rtd) & rd_of[1];

   assign fbrki = (opc_of == intu_pkg::opc_brk) & (ra_of == intu_pkg::ra_brk_imm);
   assign fbrkb = ((opc_of == intu_pkg::opc_brki) | (opc_of == intu_pkg::opc_brk))
                  & (ra_of == intu_pkg::ra_brk_bip);

   assign fmov = (opc_of == intu_pkg::opc_mov);
   assign fmts = fmov & (&imm_of.spr.mcls);
   assign fmop = fmov & ~(|imm_of.spr.mcls);

   assign fshift  = (opc_of == intu_pkg::opc_shift) & (imm_of.shf.kind != 2'b11);
   assign faddsub = ~opc_of[5] & ~opc_of[4] & ~opc_of[2];

   always_ff @(posedge gclk) begin
      if (grst) begin
         msr_dte_q <= 1'b0;
         msr_ite_q <= 1'b0;
         msr_mtx_q <= 1'b0;
         msr_bip_q <= 1'b0;
         msr_ie_q  <= 1'b0;
         msr_be_q  <= 1'b0;
         msr_c_q   <= 1'b0;
         msr_cc_q  <= 1'b0;
      end else if (dena) begin
         // Plain config bits, only moved or set/cleared
         msr_dte_q <= fmts ? opa_of[intu_pkg::msr_dte] :
                      fmop ? set_clr[intu_pkg::msr_dte] : msr_dte_q;
         msr_ite_q <= fmts ? opa_of[intu_pkg::msr_ite] :
                      fmop ? set_clr[intu_pkg::msr_ite] : msr_ite_q;
         msr_mtx_q <= fmts ? opa_of[intu_pkg::msr_mtx] :
                      fmop ? set_clr[intu_pkg::msr_mtx] : msr_mtx_q;
         msr_be_q  <= fmts ? opa_of[intu_pkg::msr_be] :
                      fmop ? set_clr[intu_pkg::msr_be] : msr_be_q;

         // Break and return win over moves
         msr_ie_q  <= fbrki ? 1'b0 :
                      frtid ? 1'b1 :
                      fmts  ? opa_of[intu_pkg::msr_ie] :
                      fmop  ? set_clr[intu_pkg::msr_ie] : msr_ie_q;
         msr_bip_q <= fbrkb ? 1'b1 :
                      frtbd ? 1'b0 :
                      fmts  ? opa_of[intu_pkg::msr_bip] :
                      fmop  ? set_clr[intu_pkg::msr_bip] : msr_bip_q;

         // Carry, otherwise reloaded from its copy
         msr_c_q   <= fmts    ? opa_of[intu_pkg::msr_c] :
                      fmop    ? set_clr[intu_pkg::msr_c] :
                      fshift  ? shift_out :
                      faddsub ? add_carry : msr_cc_q;
         msr_cc_q  <= msr_c_q;
      end
   end

endmodule

`default_nettype wire

/* intu_stage.sv */
////////////////////////////////////////
// Execute and memory-stage registers
// Result select, address/target limits, special word
////////////////////////////////////////
`default_nettype none

module intu_stage #(
   parameter int dwb_width  = 32,  // Data address bits
   parameter int iwb_width  = 32,  // Instruction address bits
   parameter int htx_enable = 1    // Thread support present
) (
   input  wire                 gclk,
   input  wire                 grst,
   input  wire                 dena,
   input  wire                 gpha,       // Current thread phase
   input  wire intu_pkg::opc_t opc_of,
   input  wire [4:0]           ra_of,
   input  wire [31:0]          opb_of,     // Absolute branch target
   input  wire [31:0]          add_res,
   input  wire [31:0]          add_sum,
   input  wire [31:0]          slm_res,
   input  wire [7:0]           msr_bits,
   input  wire                 carry_cc,
   output logic [31:0]         alu_ex,
   output logic [31:0]         alu_mx,
   output logic [31:0]         sfr_mx,
   output logic [31:2]         mem_ex,     // Word address
   output logic [31:2]         bpc_ex      // Branch target, word aligned
);

   // Keep only the implemented address bits
   localparam logic [31:0] dwb_mask = (dwb_width >= 32) ? 32'hffff_ffff
                                      : ((32'd1 << dwb_width) - 32'd1);
   localparam logic [31:0] iwb_mask = (iwb_width >= 32) ? 32'hffff_ffff
                                      : ((32'd1 << iwb_width) - 32'd1);

   logic [31:0] sfr_ex;
   logic [31:0] sfr_next;
   logic [31:0] alu_next;
   logic [31:2] bpc_next;
   logic        fbra;      // Absolute branch

   assign alu_next = opc_of[5] ? slm_res : add_res;  // Shift/logic group
   assign fbra     = ~opc_of[0] & ra_of[3];
   assign bpc_next = fbra ? opb_of[31:2] : add_sum[31:2];  // BRA, else BR/BCC/RTD

   // Special word
   // 31 CC, 30 thread support, 29 phase, 7:0 MSR with CC in the C slot
   always_comb begin
      sfr_next = 32'd0;
      sfr_next[7:0] = msr_bits;
      sfr_next[intu_pkg::msr_c] = carry_cc;
      sfr_next[29] = gpha;
      sfr_next[30] = (htx_enable != 0);
      sfr_next[31] = carry_cc;
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         alu_ex <= 32'd0;
         alu_mx <= 32'd0;
         mem_ex <= 30'd0;
         bpc_ex <= 30'd0;
         sfr_ex <= 32'd0;
         sfr_mx <= 32'd0;
      end else if (dena) begin
         alu_mx <= alu_ex;     // Memory-stage copy
         alu_ex <= alu_next;
         mem_ex <= add_sum[31:2] & dwb_mask[31:2];  // Load/store address
         bpc_ex <= bpc_next & iwb_mask[31:2];
         sfr_mx <= sfr_ex;
         sfr_ex <= sfr_next;
      end
   end

endmodule

`default_nettype wire

/* intu_top.sv */
////////////////////////////////////////
// Execute stage top level
// ALU, status unit and stage registers
////////////////////////////////////////
`default_nettype none

module intu_top #(
   parameter int dwb_width  = 32,
   parameter int iwb_width  = 32,
   parameter int htx_enable = 1
) (
   input  wire         gclk,
   input  wire         grst,
   input  wire         dena,
   input  wire         gpha,
   input  wire [5:0]   opc_of,
   input  wire [31:0]  opa_of,
   input  wire [31:0]  opb_of,
   input  wire [31:0]  opd_of,   // Store data, used past this stage
   input  wire [15:0]  imm_of,
   input  wire [4:0]   rd_of,
   input  wire [4:0]   ra_of,
   output logic [31:0] alu_ex,
   output logic [31:0] alu_mx,
   output logic [31:2] mem_ex,
   output logic [31:2] bpc_ex,
   output logic [7:0]  msr_ex,   // Live MSR flags
   output logic [31:0] sfr_mx
);

   logic [31:0] add_res;
   logic [31:0] add_sum;
   logic [31:0] slm_res;
   logic        add_carry;
   logic        shift_out;
   logic        carry_cc;    // Carry loop between ALU and MSR

   intu_alu alu_i (
      .opc_of(opc_of), .opa_of(opa_of), .opb_of(opb_of), .imm_of(imm_of),
      .carry_cc(carry_cc), .add_res(add_res), .add_sum(add_sum),
      .slm_res(slm_res), .add_carry(add_carry), .shift_out(shift_out)
   );

   intu_msr msr_i (
      .gclk(gclk), .grst(grst), .dena(dena), .opc_of(opc_of), .opa_of(opa_of),
      .imm_of(imm_of), .ra_of(ra_of), .rd_of(rd_of), .add_carry(add_carry),
      .shift_out(shift_out), .msr_bits(msr_ex), .carry_cc(carry_cc)
   );

   intu_stage #(
      .dwb_width(dwb_width), .iwb_width(iwb_width), .htx_enable(htx_enable)
   ) stage_i (
      .gclk(gclk), .grst(grst), .dena(dena), .gpha(gpha), .opc_of(opc_of),
      .ra_of(ra_of), .opb_of(opb_of), .add_res(add_res), .add_sum(add_sum),
      .slm_res(slm_res), .msr_bits(msr_ex), .carry_cc(carry_cc),
      .alu_ex(alu_ex), .alu_mx(alu_mx), .sfr_mx(sfr_mx),
      .mem_ex(mem_ex), .bpc_ex(bpc_ex)
   );

endmodule

`default_nettype wire

/* tb_intu_checks.sv */
////////////////////////////////////////
// Reference model of the execute stage
// and assertions on the DUT outputs
////////////////////////////////////////
`default_nettype none

module tb_intu_checks (
   input  wire        gclk,
   input  wire        grst,
   input  wire        dena,
   input  wire        gpha,
   input  wire [5:0]  opc_of,
   input  wire [31:0] opa_of,
   input  wire [31:0] opb_of,
   input  wire [15:0] imm_of,
   input  wire [4:0]  rd_of,
   input  wire [4:0]  ra_of,
   input  wire [31:0] alu_ex,
   input  wire [31:0] alu_mx,
   input  wire [31:2] mem_ex,
   input  wire [31:2] bpc_ex,
   input  wire [7:0]  msr_ex,
   input  wire [31:0] sfr_mx,
   output int         err_count,
   output int         chk_count
);
   timeunit 1ns;
   timeprecision 1ps;

   int          errs = 0;
   int          checks = 0;
   logic        armed = 1'b0;   // Set once the model has seen reset

   // Expected pipeline registers
   logic [31:0] e_alu_ex;
   logic [31:0] e_alu_mx;
   logic [31:0] e_sfr_ex;
   logic [31:0] e_sfr_mx;
   logic [31:2] e_mem_ex;
   logic [31:2] e_bpc_ex;

   // Model flags
   logic        m_dte;
   logic        m_ite;
   logic        m_mtx;
   logic        m_bip;
   logic        m_ie;
   logic        m_be;
   logic        m_c;
   logic        m_cc;           // C one enabled cycle late

   assign err_count = errs;
   assign chk_count = checks;

   // MSR image, bit 6 reads zero
   function automatic logic [7:0] msr_byte();
      return {m_dte, 1'b0, m_ite, m_mtx, m_bip, m_c, m_ie, m_be};
   endfunction

   task automatic check_word(input string name, input logic [31:0] got,
                             input logic [31:0] want);
      checks++;
      assert (got === want)
         else begin
            errs++;
            $display("Fail %s got %h expected %h at %0t", name, got, want, $time);
         end
   endtask

   task automatic clear_model();
      e_alu_ex = '0;
      e_alu_mx = '0;
      e_sfr_ex = '0;
      e_sfr_mx = '0;
      e_mem_ex = '0;
      e_bpc_ex = '0;
      {m_dte, m_ite, m_mtx, m_bip, m_ie, m_be, m_c, m_cc} = '0;
      armed = 1'b1;
   endtask

   // One enabled edge worth of state change
   task automatic advance_model();
      intu_pkg::imm_u imm;
      logic [7:0]     msr_now;
      logic [7:0]     nxt;
      logic [32:0]    sum;
      logic [31:0]    arith;
      logic [31:0]    slm;
      logic           sub;
      logic           use_cc;
      logic           is_mov;
      imm     = imm_of;
      msr_now = msr_byte();
      sub     = ~opc_of[5] & opc_of[0];    // b - a
      use_cc  = ~opc_of[5] & opc_of[1];    // Carry-in from CC
      sum = {1'b0, opb_of} + {1'b0, sub ? ~opa_of : opa_of}
            + {32'd0, use_cc ? m_cc : sub};
      arith = sum[31:0];
      if (!opc_of[3] && imm.shf.cmpu)
         arith[31] = ~sum[32];             // Unsigned compare, borrow in sign
      case (opc_of[2:0])
         3'd0: slm = opa_of | opb_of;
         3'd1: slm = opa_of & opb_of;
         3'd2: slm = opa_of ^ opb_of;
         3'd3: slm = opa_of & ~opb_of;
         3'd4: begin
            case ({imm.shf.kind, imm.shf.mode})
               3'b001:  slm = $signed(opa_of) >>> 1;
               3'b011:  slm = {m_cc, opa_of[31:1]};       // Through carry copy
               3'b101:  slm = opa_of >> 1;
               3'b110:  slm = 32'($signed(opa_of[7:0]));
               3'b111:  slm = 32'($signed(opa_of[15:0]));
               default: slm = '0;
            endcase
         end
         default: slm = '0;
      endcase
      // Flags after move or set/clear
      is_mov = (opc_of == intu_pkg::opc_mov);
      if (is_mov && imm.spr.mcls == 2'b11)
         nxt = opa_of[7:0];
      else if (is_mov && imm.spr.mcls == 2'b00)
         nxt = ra_of[0] ? (msr_now & ~imm.spr.mask) : (msr_now | imm.spr.mask);
      else begin
         nxt = msr_now;
         if (opc_of == intu_pkg::opc_shift && imm.shf.kind != 2'b11)
            nxt[2] = opa_of[0];            // Shifted-out bit
         else if (opc_of[5:4] == 2'b00 && !opc_of[2])
            nxt[2] = sum[32];
         else
            nxt[2] = m_cc;
      end
      if (opc_of == intu_pkg::opc_brk && ra_of == 5'd13)
         nxt[1] = 1'b0;
      else if (opc_of == intu_pkg::opc_rtd && rd_of[0])
         nxt[1] = 1'b1;
      if ((opc_of == intu_pkg::opc_brk || opc_of == intu_pkg::opc_brki) && ra_of == 5'd12)
         nxt[3] = 1'b1;
      else if (opc_of == intu_pkg::opc_rtd && rd_of[1])
         nxt[3] = 1'b0;
      // Registers, old values first
      e_sfr_mx = e_sfr_ex;
      e_sfr_ex = {m_cc, 1'b1, gpha, 21'd0, msr_now[7:3], m_cc, msr_now[1:0]};
      e_alu_mx = e_alu_ex;
      e_alu_ex = opc_of[5] ? slm : arith;
      e_mem_ex = sum[31:2];
      e_bpc_ex = (!opc_of[0] && ra_of[3]) ? opb_of[31:2] : sum[31:2];  // Absolute
      m_cc  = m_c;
      {m_dte, m_ite, m_mtx, m_bip, m_c, m_ie, m_be} = {nxt[7], nxt[5:0]};
   endtask

   // Outputs settle between edges
   always @(negedge gclk) begin
      if (armed) begin
         check_word("alu_ex", alu_ex, e_alu_ex);
         check_word("alu_mx", alu_mx, e_alu_mx);
         check_word("mem_ex", {2'b00, mem_ex}, {2'b00, e_mem_ex});
         check_word("bpc_ex", {2'b00, bpc_ex}, {2'b00, e_bpc_ex});
         check_word("msr_ex", {24'd0, msr_ex}, {24'd0, msr_byte()});
         check_word("sfr_mx", sfr_mx, e_sfr_mx);
      end
      if (grst)
         clear_model();
      else if (dena)
         advance_model();
   end

endmodule

`default_nettype wire

/* tb_intu.sv */
////////////////////////////////////////
// Execute stage testbench top
// Clock, reset, random instruction classes,
// timeout and closing report
////////////////////////////////////////
`default_nettype none

module tb_intu;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int n_instr = 300;   // Instructions per test
   localparam int n_tests = 7;
   localparam int max_cycles = 8 + n_tests * n_instr + 50;

   // Status group opcodes
   localparam intu_pkg::opc_t status_ops [4] = '{intu_pkg::opc_mov, intu_pkg::opc_brk,
                                                 intu_pkg::opc_brki, intu_pkg::opc_rtd};

   logic        gclk;
   logic        grst;
   logic        dena;
   logic        gpha;
   logic [5:0]  opc_of;
   logic [31:0] opa_of;
   logic [31:0] opb_of;
   logic [31:0] opd_of;
   logic [15:0] imm_of;
   logic [4:0]  rd_of;
   logic [4:0]  ra_of;
   logic [31:0] alu_ex;
   logic [31:0] alu_mx;
   logic [31:2] mem_ex;
   logic [31:2] bpc_ex;
   logic [7:0]  msr_ex;
   logic [31:0] sfr_mx;
   int          err_count;
   int          chk_count;
   int          cycles = 0;

   intu_top dut_i (
      .gclk(gclk), .grst(grst), .dena(dena), .gpha(gpha), .opc_of(opc_of),
      .opa_of(opa_of), .opb_of(opb_of), .opd_of(opd_of), .imm_of(imm_of),
      .rd_of(rd_of), .ra_of(ra_of), .alu_ex(alu_ex), .alu_mx(alu_mx),
      .mem_ex(mem_ex), .bpc_ex(bpc_ex), .msr_ex(msr_ex), .sfr_mx(sfr_mx)
   );

   tb_intu_checks chk_i (
      .gclk(gclk), .grst(grst), .dena(dena), .gpha(gpha), .opc_of(opc_of),
      .opa_of(opa_of), .opb_of(opb_of), .imm_of(imm_of), .rd_of(rd_of),
      .ra_of(ra_of), .alu_ex(alu_ex), .alu_mx(alu_mx), .mem_ex(mem_ex),
      .bpc_ex(bpc_ex), .msr_ex(msr_ex), .sfr_mx(sfr_mx),
      .err_count(err_count), .chk_count(chk_count)
   );

   initial begin
      gclk = 1'b0;
      forever #4 gclk = ~gclk;     // 8 ns period
   end

   always @(posedge gclk) begin
      cycles = cycles + 1;
      if (cycles >= max_cycles) begin
         $display("Timeout, run stopped after %0d cycles", cycles);
         $display("tests failed");
         $finish;
      end
   end

   // Random instructions of one class
   // 0 add/sub/cmp, 1 logic, 2 shift, 3 status, 4 any, 5 mostly idle, 6 with resets
   task automatic run_test(input int cls, input int en_pct);
      logic [31:0] r;
      logic [31:0] s;
      for (int i = 0; i < n_instr; i++) begin
         @(posedge gclk);
         r = $urandom();
         s = $urandom();
         dena   <= ($urandom_range(99, 0) < en_pct);
         grst   <= (cls == 6) && (r[30:28] == 3'd0);  // Occasional reset
         gpha   <= r[31];
         opa_of <= $urandom();
         opb_of <= $urandom();
         opd_of <= $urandom();
         imm_of <= s[15:0];
         rd_of  <= s[20:16];
         ra_of  <= r[14:10];
         case (cls)
            0: opc_of <= {2'b00, r[3:0]};
            1: opc_of <= {1'b1, r[4:3], 1'b0, r[1:0]};
            2: opc_of <= intu_pkg::opc_shift;
            3: begin
               opc_of <= status_ops[r[5:4]];
               if (r[9])
                  ra_of <= {4'b0110, r[10]};      // Break codes 12 and 13
            end
            default: opc_of <= r[5:0];
         endcase
      end
   endtask

   initial begin
      void'($urandom(32'h17f7_4a72));
      grst   = 1'b1;
      dena   = 1'b0;
      gpha   = 1'b0;
      opc_of = '0;
      opa_of = '0;
      opb_of = '0;
      opd_of = '0;
      imm_of = '0;
      rd_of  = '0;
      ra_of  = '0;
      repeat (8) @(posedge gclk);
      grst <= 1'b0;
      run_test(0, 80);
      run_test(1, 80);
      run_test(2, 80);
      run_test(3, 80);
      run_test(4, 80);
      run_test(5, 20);    // Hold behavior
      run_test(6, 80);
      @(posedge gclk);
      grst <= 1'b0;
      dena <= 1'b0;
      repeat (4) @(posedge gclk);
      $display("checks %0d errors %0d", chk_count, err_count);
      if (err_count == 0 && chk_count > 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
intu_pkg.sv
intu_alu.sv
intu_msr.sv
intu_stage.sv
intu_top.sv
tb_intu_checks.sv
tb_intu.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
   --top-module tb_intu -f verilog.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/Vtb_intu)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "all tests passed" <<< "$output"; then
   exit 0
fi
exit 1
